/* hw/load_pkg.sv */
// ---------------------------------------------------------------------
// load unit package
// shared widths, load operation codes and the packed types that travel
// between the issuer, the pending queue, the aligner and the data cache
// ---------------------------------------------------------------------

`default_nettype none

package load_pkg;

    // physical address and cache address split
    parameter int unsigned PlenWidth        = 32;
    parameter int unsigned DcacheIndexWidth = 12;
    parameter int unsigned DcacheTagWidth   = 20;

    // transaction id and data widths
    parameter int unsigned TransIdWidth = 3;
    parameter int unsigned XlenWidth    = 64;

    // byte offset inside one doubleword
    parameter int unsigned OffsetWidth = $clog2(XlenWidth / 8);

    // load operations, integer loads first and then the floating-point loads
    typedef enum logic [3:0] {
        LB, LH, LW, LD,
        LBU, LHU, LWU,
        FLB, FLH, FLW, FLD
    } load_op_e;

    // a load request as it arrives from outside
    typedef struct packed {
        logic [TransIdWidth-1:0] trans_id;
        logic [PlenWidth-1:0]    paddr;
        load_op_e                op;
    } load_req_t;

    // metadata kept for every load that waits for its data
    typedef struct packed {
        logic [TransIdWidth-1:0] trans_id;
        logic [OffsetWidth-1:0]  offset;
        load_op_e                op;
    } pending_entry_t;

    // read side of the cache port, index phase then tag phase
    typedef struct packed {
        logic                        data_req;
        logic [DcacheIndexWidth-1:0] index;
        logic                        tag_valid;
        logic [DcacheTagWidth-1:0]   tag;
        logic [1:0]                  size;
    } dcache_req_t;

    // the returned cache word seen as bytes, halfwords, words or one doubleword
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } load_data_u;

    // aligned and extended result handed back to the requester
    typedef struct packed {
        logic                    valid;
        logic [TransIdWidth-1:0] trans_id;
        logic [XlenWidth-1:0]    data;
    } load_result_t;

    // log2 of the access size in bytes for each load operation
    function automatic logic [1:0] op_size(input load_op_e op);
        logic [1:0] size;
        case (op)
            LB, LBU, FLB: size = 2'd0;
            LH, LHU, FLH: size = 2'd1;
            LW, LWU, FLW: size = 2'd2;
            default:      size = 2'd3;
        endcase
        return size;
    endfunction

endpackage

`default_nettype wire

/* hw/load_issue.sv */
// ---------------------------------------------------------------------
// load issuer
// sends the index phase of each request to the data cache, then the
// tag phase exactly one cycle after the grant, and pushes the load's
// metadata into the pending queue while spending one credit per load
// ---------------------------------------------------------------------

`default_nettype none

module load_issue #(
    parameter int unsigned NrPending = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // request port from outside
    input  logic                     req_valid_i,
    input  load_pkg::load_req_t      req_i,
    output logic                     req_ready_o,
    // data cache port
    input  logic                     dcache_gnt_i,
    output load_pkg::dcache_req_t    dcache_req_o,
    // pending queue port
    input  logic                     credit_return_i,
    output logic                     push_valid_o,
    output load_pkg::pending_entry_t push_entry_o
);

    // the counter has to hold the full credit count, hence one value more
    localparam int unsigned CntWidth = $clog2(NrPending + 1);

    typedef enum logic {
        IDLE,
        SEND_TAG
    } state_e;

    state_e                                state_d, state_q;
    logic [CntWidth-1:0]                   credit_d, credit_q;
    logic [load_pkg::DcacheTagWidth-1:0]   tag_q;
    logic                                  has_credit;
    logic                                  data_req;
    logic                                  granted;

    // ---------------------------------------------------------------------
    // index phase
    // ---------------------------------------------------------------------

    // only ask the cache when the queue is sure to have room for the entry
    assign has_credit = (credit_q != '0);
    assign data_req   = req_valid_i & has_credit;
    assign granted    = data_req & dcache_gnt_i;

    // the requester sees ready exactly in the grant cycle
    assign req_ready_o  = granted;
    assign push_valid_o = granted;

    // the queue keeps what the aligner needs once the data comes back
    assign push_entry_o.trans_id = req_i.trans_id;
    assign push_entry_o.offset   = req_i.paddr[load_pkg::OffsetWidth-1:0];
    assign push_entry_o.op       = req_i.op;

    // index comes straight from the held request, tag from the register
    assign dcache_req_o.data_req  = data_req;
    assign dcache_req_o.index     = req_i.paddr[load_pkg::DcacheIndexWidth-1:0];
    assign dcache_req_o.tag_valid = (state_q == SEND_TAG);
    assign dcache_req_o.tag       = tag_q;
    assign dcache_req_o.size      = load_pkg::op_size(req_i.op);

    // ---------------------------------------------------------------------
    // tag phase and credits
    // ---------------------------------------------------------------------

    always_comb begin
        // a grant always leads to one tag cycle, and a new grant may
        // land in that same tag cycle
        state_d = granted ? SEND_TAG : IDLE;

        // spend on a grant, regain on a returned credit, both may coincide
        case ({granted, credit_return_i})
            2'b10:   credit_d = credit_q - CntWidth'(1);
            2'b01:   credit_d = credit_q + CntWidth'(1);
            default: credit_d = credit_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            // every queue slot starts free
            credit_q <= CntWidth'(NrPending);
        end else begin
            state_q  <= state_d;
            credit_q <= credit_d;
        end
    end

    // upper address bits are sent in the cycle after the grant
    always_ff @(posedge clk_i) begin
        if (granted) begin
            tag_q <= req_i.paddr[load_pkg::PlenWidth-1:load_pkg::DcacheIndexWidth];
        end
    end

endmodule

`default_nettype wire

/* hw/load_pending_queue.sv */
// ---------------------------------------------------------------------
// pending load queue
// circular FIFO that holds the metadata of outstanding loads in issue
// order, shows the oldest entry to the aligner and hands one credit
// back to the issuer for every entry that leaves
// ---------------------------------------------------------------------

`default_nettype none

module load_pending_queue #(
    parameter int unsigned NrPending = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // push side from the issuer
    input  logic                     push_valid_i,
    input  load_pkg::pending_entry_t push_entry_i,
    // pop side towards the aligner
    input  logic                     pop_i,
    output load_pkg::pending_entry_t head_o,
    // credit back to the issuer
    output logic                     credit_return_o
);

    // a single slot still needs a one bit pointer
    localparam int unsigned PtrWidth = (NrPending > 1) ? $clog2(NrPending) : 1;

    load_pkg::pending_entry_t mem_q [NrPending];
    logic [PtrWidth-1:0]      wptr_q, rptr_q;
    logic                     credit_q;

    // pointers wrap at the queue depth, which need not be a power of two
    function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
        logic [PtrWidth-1:0] nxt;
        if (ptr == PtrWidth'(NrPending - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PtrWidth'(1);
        end
        return nxt;
    endfunction

    // ---------------------------------------------------------------------
    // storage
    // ---------------------------------------------------------------------

    // the issuer never pushes without a credit, so a full queue is never written
    always_ff @(posedge clk_i) begin
        if (push_valid_i) begin
            mem_q[wptr_q] <= push_entry_i;
        end
    end

    // oldest entry goes out without a register stage
    assign head_o = mem_q[rptr_q];

    // ---------------------------------------------------------------------
    // pointers and credit return
    // ---------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q   <= '0;
            rptr_q   <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push_valid_i) begin
                wptr_q <= ptr_next(wptr_q);
            end
            if (pop_i) begin
                rptr_q <= ptr_next(rptr_q);
            end
            // the freed slot is announced one cycle after the pop
            credit_q <= pop_i;
        end
    end

    assign credit_return_o = credit_q;

endmodule

`default_nettype wire

/* hw/load_align.sv */
// ---------------------------------------------------------------------
// load aligner
// picks the loaded field out of the returned cache word by the load's
// byte offset and size, then sign-extends, zero-extends or NaN-boxes
// it, purely combinational
// ---------------------------------------------------------------------

`default_nettype none

module load_align (
    // data returned by the cache
    input  logic                     rvalid_i,
    input  load_pkg::load_data_u     rdata_i,
    // metadata of the oldest outstanding load
    input  load_pkg::pending_entry_t head_i,
    // result towards the requester
    output load_pkg::load_result_t   result_o
);

    logic [1:0]  size;
    logic        is_signed;
    logic        is_fp;
    logic [7:0]  byte_field;
    logic [15:0] half_field;
    logic [31:0] word_field;
    logic        top_bit;
    logic        fill_bit;

    // ---------------------------------------------------------------------
    // field select
    // ---------------------------------------------------------------------

    assign size      = load_pkg::op_size(head_i.op);
    assign is_signed = head_i.op inside {load_pkg::LB, load_pkg::LH, load_pkg::LW};
    assign is_fp     = head_i.op inside {load_pkg::FLB, load_pkg::FLH, load_pkg::FLW};

    // aligned loads only, so the upper offset bits index the wider views
    assign byte_field = rdata_i.b[head_i.offset];
    assign half_field = rdata_i.h[head_i.offset[2:1]];
    assign word_field = rdata_i.w[head_i.offset[2]];

    // ---------------------------------------------------------------------
    // extension
    // ---------------------------------------------------------------------

    always_comb begin
        // most significant bit of the selected field
        case (size)
            2'd0:    top_bit = byte_field[7];
            2'd1:    top_bit = half_field[15];
            2'd2:    top_bit = word_field[31];
            default: top_bit = rdata_i.d[63];
        endcase

        // signed loads copy the top bit, narrow fp loads are boxed with ones,
        // everything else is filled with zeros
        if (is_signed) begin
            fill_bit = top_bit;
        end else begin
            fill_bit = is_fp;
        end
    end

    always_comb begin
        result_o.valid    = rvalid_i;
        result_o.trans_id = head_i.trans_id;
        case (size)
            2'd0:    result_o.data = {{56{fill_bit}}, byte_field};
            2'd1:    result_o.data = {{48{fill_bit}}, half_field};
            2'd2:    result_o.data = {{32{fill_bit}}, word_field};
            // LD and FLD hand the doubleword back untouched
            default: result_o.data = rdata_i.d;
        endcase
    end

endmodule

`default_nettype wire

/* hw/load_unit_top.sv */
// ---------------------------------------------------------------------
// load unit top level
// the issuer drives the cache in index and tag phases, the pending
// queue keeps the outstanding loads in order and the aligner shapes
// each returned word into the result
// ---------------------------------------------------------------------

`default_nettype none

module load_unit_top #(
    parameter int unsigned NrPending = 2
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // request port
    input  logic                   req_valid_i,
    input  load_pkg::load_req_t    req_i,
    output logic                   req_ready_o,
    // data cache port
    output load_pkg::dcache_req_t  dcache_req_o,
    input  logic                   dcache_gnt_i,
    input  logic                   dcache_rvalid_i,
    input  load_pkg::load_data_u   dcache_rdata_i,
    // result port, no back-pressure
    output load_pkg::load_result_t result_o
);

    logic                     push_valid;
    load_pkg::pending_entry_t push_entry;
    logic                     credit_return;
    load_pkg::pending_entry_t head;

    load_issue #(
        .NrPending (NrPending)
    ) i_issue (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .dcache_gnt_i    (dcache_gnt_i),
        .dcache_req_o    (dcache_req_o),
        .credit_return_i (credit_return),
        .push_valid_o    (push_valid),
        .push_entry_o    (push_entry)
    );

    // data returns in order, so every rvalid retires the head entry
    load_pending_queue #(
        .NrPending (NrPending)
    ) i_pending_queue (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .push_valid_i    (push_valid),
        .push_entry_i    (push_entry),
        .pop_i           (dcache_rvalid_i),
        .head_o          (head),
        .credit_return_o (credit_return)
    );

    load_align i_align (
        .rvalid_i (dcache_rvalid_i),
        .rdata_i  (dcache_rdata_i),
        .head_i   (head),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

/* testbench/load_unit_assertions.sv */
// ---------------------------------------------------------------------
// load unit protocol assertions
// checks the two-phase cache handshake, the outstanding load limit,
// alignment of issued loads and quiet outputs during reset
// ---------------------------------------------------------------------

`default_nettype none

module load_unit_assertions #(
    parameter int unsigned NrPending = 2
) (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   req_valid_i,
    input load_pkg::load_req_t    req_i,
    input logic                   req_ready_o,
    input load_pkg::dcache_req_t  dcache_req_o,
    input logic                   dcache_gnt_i,
    input logic                   dcache_rvalid_i,
    input load_pkg::load_result_t result_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // accepted minus returned loads
    int unsigned inflight_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            inflight_q <= 0;
        end else begin
            inflight_q <= inflight_q + 32'(req_ready_o) - 32'(dcache_rvalid_i);
        end
    end

    // the cache only sees a request that is valid at the input
    req_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.data_req |-> req_valid_i)
        else $error("cache request without a valid load request");

    index_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.data_req && !dcache_gnt_i
        |=> dcache_req_o.data_req && $stable(dcache_req_o.index))
        else $error("index changed or request dropped before the grant");

    // tag goes out one cycle after the grant with the upper address bits
    tag_after_grant_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.data_req && dcache_gnt_i
        |=> dcache_req_o.tag_valid && dcache_req_o.tag ==
            $past(req_i.paddr[load_pkg::PlenWidth-1:load_pkg::DcacheIndexWidth]))
        else $error("tag phase missing or carrying the wrong address");

    tag_only_after_grant_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.tag_valid |-> $past(dcache_req_o.data_req && dcache_gnt_i))
        else $error("tag phase without a grant in the cycle before");

    inflight_limit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inflight_q <= NrPending)
        else $error("more loads outstanding than the queue can hold");

    ready_at_limit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inflight_q == NrPending |-> !req_ready_o)
        else $error("request accepted with the queue full");

    // the low address bits below the access size have to be zero
    aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.data_req |-> (req_i.paddr[2:0] & ~(3'b111 << dcache_req_o.size)) == 3'b000)
        else $error("misaligned load sent to the cache");

    result_outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_o.valid |-> inflight_q != 0)
        else $error("result with no load outstanding");

    reset_quiet_a: assert property (@(posedge clk_i)
        !rst_ni |-> !dcache_req_o.data_req && !dcache_req_o.tag_valid
                    && !req_ready_o && !result_o.valid)
        else $error("control output active during reset");

endmodule

`default_nettype wire

/* testbench/tb_load_unit.sv */
// ---------------------------------------------------------------------
// load unit testbench
// drives aligned loads of every kind into the load unit, models a data
// cache with random grants and in-order delayed returns, and checks
// every result against the extension rule of its load
// ---------------------------------------------------------------------

`default_nettype none

module tb_load_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned NrPending     = 2;
    localparam int unsigned NumLoads      = 300;
    localparam int unsigned TimeoutCycles = 40 * NumLoads;
    localparam int unsigned DrainCycles   = 10;

    // one cache word on its way back, held until its due cycle
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] due;
    } cache_ret_t;

    logic                                  clk_i;
    logic                                  rst_ni;
    logic                                  req_valid_i;
    load_pkg::load_req_t                   req_i;
    logic                                  req_ready_o;
    load_pkg::dcache_req_t                 dcache_req_o;
    logic                                  dcache_gnt_i;
    logic                                  dcache_rvalid_i;
    load_pkg::load_data_u                  dcache_rdata_i;
    load_pkg::load_result_t                result_o;

    // the requester and the cache model draw from separate streams
    logic [31:0]                           req_rng;
    logic [31:0]                           cache_rng;
    int unsigned                           cycle_cnt;
    int unsigned                           next_load;
    int unsigned                           result_cnt;
    logic                                  req_held;
    logic [load_pkg::DcacheIndexWidth-1:0] index_q;
    load_pkg::load_req_t                   expect_q[$];
    cache_ret_t                            ret_q[$];

    load_unit_top #(
        .NrPending (NrPending)
    ) uut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .dcache_req_o    (dcache_req_o),
        .dcache_gnt_i    (dcache_gnt_i),
        .dcache_rvalid_i (dcache_rvalid_i),
        .dcache_rdata_i  (dcache_rdata_i),
        .result_o        (result_o)
    );

    // protocol checks ride along with the load unit
    bind load_unit_top load_unit_assertions #(
        .NrPending (NrPending)
    ) i_assertions (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .dcache_req_o    (dcache_req_o),
        .dcache_gnt_i    (dcache_gnt_i),
        .dcache_rvalid_i (dcache_rvalid_i),
        .result_o        (result_o)
    );

    // ---------------------------------------------------------------------
    // reference model
    // ---------------------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned access_bytes(input load_pkg::load_op_e op);
        int unsigned bytes;
        case (op)
            load_pkg::LB, load_pkg::LBU, load_pkg::FLB: bytes = 1;
            load_pkg::LH, load_pkg::LHU, load_pkg::FLH: bytes = 2;
            load_pkg::LW, load_pkg::LWU, load_pkg::FLW: bytes = 4;
            default:                                    bytes = 8;
        endcase
        return bytes;
    endfunction

    // memory content is a fixed hash of the doubleword address
    function automatic logic [63:0] word_hash(input logic [28:0] dw_addr);
        logic [31:0] a;
        logic [31:0] hi;
        logic [31:0] lo;
        a  = {3'b000, dw_addr};
        hi = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        lo = (a * 32'h85eb_ca6b) ^ {hi[15:0], hi[31:16]};
        return {hi, lo};
    endfunction

    // sign, zero or ones fill above the loaded field, LD and FLD untouched
    function automatic logic [63:0] expected_data(input load_pkg::load_op_e op,
                                                  input logic [2:0] offset,
                                                  input logic [63:0] word);
        logic [63:0] sh;
        logic [63:0] res;
        sh = word >> {offset, 3'b000};
        case (op)
            load_pkg::LB:  res = {{56{sh[7]}}, sh[7:0]};
            load_pkg::LH:  res = {{48{sh[15]}}, sh[15:0]};
            load_pkg::LW:  res = {{32{sh[31]}}, sh[31:0]};
            load_pkg::LBU: res = {56'h0, sh[7:0]};
            load_pkg::LHU: res = {48'h0, sh[15:0]};
            load_pkg::LWU: res = {32'h0, sh[31:0]};
            load_pkg::FLB: res = {{56{1'b1}}, sh[7:0]};
            load_pkg::FLH: res = {{48{1'b1}}, sh[15:0]};
            load_pkg::FLW: res = {{32{1'b1}}, sh[31:0]};
            default:       res = word;
        endcase
        return res;
    endfunction

    // ops rotate and the offset sweeps, so each op meets each aligned offset
    function automatic load_pkg::load_req_t build_request(input int unsigned n,
                                                          input logic [31:0] rnd);
        load_pkg::load_req_t req;
        logic [2:0]          offset;
        req.op       = load_pkg::load_op_e'(4'(n % 11));
        offset       = 3'((n / 11) % 8) & ~3'(access_bytes(req.op) - 1);
        req.trans_id = 3'(n);
        req.paddr    = {rnd[31:3], offset};
        return req;
    endfunction

    task automatic abort_run(input string reason);
        $display("Test FAILED");
        $fatal(1, "%s", reason);
    endtask

    // ---------------------------------------------------------------------
    // stimulus, cache model and scoreboard
    // ---------------------------------------------------------------------

    task automatic drive_inputs();
        cache_ret_t ret;
        // a request stays on the port until the cycle it is accepted
        if (!req_held) begin
            req_rng = lcg_next(req_rng);
            if (next_load < NumLoads && req_rng[22:21] != 2'b00) begin
                req_rng     = lcg_next(req_rng);
                req_i       = build_request(next_load, req_rng);
                req_valid_i = 1'b1;
                req_held    = 1'b1;
            end else begin
                req_valid_i = 1'b0;
            end
        end
        cache_rng = lcg_next(cache_rng);
        // roughly three grants in four cycles
        dcache_gnt_i = (cache_rng[25:24] != 2'b00);
        if (ret_q.size() > 0 && ret_q[0].due <= cycle_cnt) begin
            ret              = ret_q.pop_front();
            dcache_rvalid_i  = 1'b1;
            dcache_rdata_i.d = word_hash(ret.addr[31:3]);
        end else begin
            dcache_rvalid_i  = 1'b0;
            dcache_rdata_i.d = {cache_rng, ~cache_rng};
        end
    endtask

    task automatic check_result();
        load_pkg::load_req_t exp_req;
        load_pkg::load_op_e  op;
        logic [63:0]         exp_data;
        if (expect_q.size() == 0) begin
            abort_run("a result arrived while no accepted load was outstanding");
        end else begin
            exp_req  = expect_q.pop_front();
            op       = exp_req.op;
            exp_data = expected_data(op, exp_req.paddr[2:0], word_hash(exp_req.paddr[31:3]));
            if (result_o.trans_id != exp_req.trans_id) begin
                $display("error at %0t: expected trans_id %0d, got %0d",
                         $time, exp_req.trans_id, result_o.trans_id);
                abort_run("results left acceptance order");
            end else if (result_o.data != exp_data) begin
                $display("error at %0t: %s at offset %0d expected %h, got %h",
                         $time, op.name(), exp_req.paddr[2:0], exp_data, result_o.data);
                abort_run("a load returned wrong data");
            end else begin
                result_cnt = result_cnt + 1;
            end
        end
    endtask

    // everything is read in the second half of the low clock phase, after the
    // inputs settled and before the rising edge moves the flops
    task automatic sample_outputs();
        cache_ret_t  ret;
        int unsigned delay;
        int unsigned exp_size;
        cycle_cnt = cycle_cnt + 1;
        exp_size  = $clog2(access_bytes(req_i.op));
        if (cycle_cnt >= TimeoutCycles) begin
            abort_run("timeout, the loads did not finish within the cycle limit");
        end else if (dcache_req_o.data_req && dcache_req_o.size != 2'(exp_size)) begin
            $display("error at %0t: %s expected size %0d, got %0d",
                     $time, req_i.op.name(), exp_size, dcache_req_o.size);
            abort_run("the cache request carried the wrong access size");
        end else begin
            if (req_ready_o) begin
                expect_q.push_back(req_i);
                next_load = next_load + 1;
                req_held  = 1'b0;
            end
            // the tag completes the address whose index was granted a cycle ago
            if (dcache_req_o.tag_valid) begin
                cache_rng = lcg_next(cache_rng);
                delay     = 1 + int'(cache_rng[29:27]) % 6;
                ret.addr  = {dcache_req_o.tag, index_q};
                ret.due   = cycle_cnt + delay - 1;
                ret_q.push_back(ret);
            end
            if (dcache_req_o.data_req && dcache_gnt_i) begin
                index_q = dcache_req_o.index;
            end
            if (result_o.valid) begin
                check_result();
            end
        end
    endtask

    task automatic run_cycle();
        @(negedge clk_i);
        drive_inputs();
        #5;
        sample_outputs();
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        rst_ni          = 1'b0;
        req_valid_i     = 1'b0;
        req_i           = '0;
        dcache_gnt_i    = 1'b0;
        dcache_rvalid_i = 1'b0;
        dcache_rdata_i  = '0;
        req_rng         = 32'hd304;
        // the cache stream starts from the inverted seed
        cache_rng       = ~32'hd304;
        cycle_cnt       = 0;
        next_load       = 0;
        result_cnt      = 0;
        req_held        = 1'b0;
        index_q         = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        while (result_cnt < NumLoads) begin
            run_cycle();
        end
        // idle cycles at the end catch any result nobody asked for
        repeat (DrainCycles) begin
            run_cycle();
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/load_pkg.sv
hw/load_issue.sv
hw/load_pending_queue.sv
hw/load_align.sv
hw/load_unit_top.sv
testbench/load_unit_assertions.sv
testbench/tb_load_unit.sv

/* run_sim.sh */
#!/bin/sh
# build the load unit testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_load_unit \
    --Mdir obj_dir \
    -f flist.f \
    && ./obj_dir/Vtb_load_unit \
    || exit 1
